//--- src/fpm_pkg.sv
package fpm_pkg;

  ////////////////////
  // field widths
  ////////////////////

  // shared by both operands
  localparam int EXP_W    = 5;
  // half precision operand a and the result
  localparam int A_FRAC_W = 10;
  // short float operand b
  localparam int B_FRAC_W = 4;

  // exponent encoding
  localparam int EXP_BIAS = 15;
  // all ones exponent, infinity
  localparam int EXP_MAX  = 31;

  ////////////////////
  // datapath widths
  ////////////////////

  // significands with the hidden one
  localparam int A_SIG_W = A_FRAC_W + 1;
  // also the partial product count
  localparam int B_SIG_W = B_FRAC_W + 1;

  // full significand product
  localparam int PROD_W = A_SIG_W + B_SIG_W;

  // two biased exponents plus the normalization carry
  localparam int SUM_W = EXP_W + 2;

  // product count after each adder tree level, 5 -> 3 -> 2 -> 1
  localparam int TREE_N1 = (B_SIG_W + 1) / 2;
  localparam int TREE_N2 = (TREE_N1 + 1) / 2;
  localparam int TREE_N3 = (TREE_N2 + 1) / 2;

  ////////////////////
  // types
  ////////////////////

  // operand a and the result, 16 bits
  typedef struct packed {
    logic                sign;
    logic [EXP_W-1:0]    exp;
    logic [A_FRAC_W-1:0] frac;
  } half_t;

  // operand b, 10 bits
  typedef struct packed {
    logic                sign;
    logic [EXP_W-1:0]    exp;
    logic [B_FRAC_W-1:0] frac;
  } short_t;

  // metadata that rides beside the products, 10 bits
  typedef struct packed {
    logic             sign;
    logic [SUM_W-1:0] exp_sum;
    logic             is_zero;
    logic             is_inf;
  } op_meta_t;

  // one partial product or partial sum
  typedef logic [PROD_W-1:0] pp_t;

endpackage

//--- src/fpm_decode.sv
`timescale 1ns/1ps

module fpm_decode (
  input  logic              CLK,
  input  logic              Reset,
  input  fpm_pkg::half_t    a,
  input  fpm_pkg::short_t   b,
  output fpm_pkg::pp_t      pp [fpm_pkg::B_SIG_W],
  output fpm_pkg::op_meta_t meta
);

  import fpm_pkg::*;

  // significands, hidden one always set
  logic [A_SIG_W-1:0] sig_a;
  logic [B_SIG_W-1:0] sig_b;

  // next state of the stage registers
  pp_t      pp_next [B_SIG_W];
  op_meta_t meta_next;

  ////////////////////
  // field split
  ////////////////////

  // zero exponents still get the one here
  // is_zero overrides the result later
  assign sig_a = {1'b1, a.frac};
  assign sig_b = {1'b1, b.frac};

  ////////////////////
  // partial products
  ////////////////////

  // shift and add, one row per bit of sig_b
  always_comb
  begin
    for (int i = 0; i < B_SIG_W; i++)
    begin
      if (sig_b[i])
        pp_next[i] = pp_t'(sig_a) << i;
      else
        pp_next[i] = '0;
    end
  end

  ////////////////////
  // metadata
  ////////////////////

  always_comb
  begin
    meta_next.sign    = a.sign ^ b.sign;
    // both exponents still biased, bias comes off in the last stage
    meta_next.exp_sum = SUM_W'(a.exp) + SUM_W'(b.exp);
    // subnormals count as zero
    meta_next.is_zero = (a.exp == '0) || (b.exp == '0);
    // exponent 31 is infinity, fraction ignored
    meta_next.is_inf  = (a.exp == EXP_W'(EXP_MAX)) || (b.exp == EXP_W'(EXP_MAX));
  end

  // stage 1 registers
  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
    begin
      pp   <= '{default: '0};
      meta <= '0;
    end
    else
    begin
      pp   <= pp_next;
      meta <= meta_next;
    end
  end

endmodule

//--- src/fpm_adder_level.sv
`timescale 1ns/1ps

module fpm_adder_level #(
  parameter  int  N_IN      = 5,
  parameter  type payload_t = fpm_pkg::op_meta_t,
  localparam int  N_OUT     = (N_IN + 1) / 2
) (
  input  logic         CLK,
  input  logic         Reset,
  input  fpm_pkg::pp_t pp_in [N_IN],
  input  payload_t     side_in,
  output fpm_pkg::pp_t pp_out [N_OUT],
  output payload_t     side_out
);

  import fpm_pkg::*;

  ////////////////////
  // pairwise sums
  ////////////////////

  // neighbours 2i and 2i+1 land in output i
  for (genvar i = 0; i < N_OUT; i++)
  begin : g_pair
    if (2 * i + 1 < N_IN)
    begin : g_sum
      // partial sums never exceed the full product, no carry out
      always_ff @(posedge CLK or posedge Reset)
      begin
        if (Reset)
          pp_out[i] <= '0;
        else
          pp_out[i] <= pp_in[2 * i] + pp_in[2 * i + 1];
      end
    end
    else
    begin : g_pass
      // odd one out, just delayed
      always_ff @(posedge CLK or posedge Reset)
      begin
        if (Reset)
          pp_out[i] <= '0;
        else
          pp_out[i] <= pp_in[2 * i];
      end
    end
  end

  ////////////////////
  // payload delay
  ////////////////////

  // one cycle, same as the sums
  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
      side_out <= '0;
    else
      side_out <= side_in;
  end

endmodule

//--- src/fpm_normalize.sv
`timescale 1ns/1ps

module fpm_normalize (
  input  logic              CLK,
  input  logic              Reset,
  input  fpm_pkg::pp_t      prod,
  input  fpm_pkg::op_meta_t meta,
  output fpm_pkg::half_t    z
);

  import fpm_pkg::*;

  // product of two values in [1, 2) lies in [1, 4)
  logic                carry;
  logic [SUM_W-1:0]    exp_norm;
  logic [A_FRAC_W-1:0] frac_norm;

  // exponent after bias removal, valid only in range
  logic [EXP_W-1:0]    exp_res;

  // range checks on the still biased sum
  logic                exp_ovf;
  logic                exp_unf;

  half_t               z_next;

  ////////////////////
  // one bit normalize
  ////////////////////

  assign carry = prod[PROD_W-1];

  // exp_sum holds two biases, carry bumps it by one
  assign exp_norm = meta.exp_sum + SUM_W'(carry);

  // ten bits below the leading one, rest truncated
  assign frac_norm = carry ? prod[PROD_W-2 -: A_FRAC_W] : prod[PROD_W-3 -: A_FRAC_W];

  ////////////////////
  // bias removal
  ////////////////////

  // result exponent = exp_norm - bias
  // >= EXP_MAX means overflow
  assign exp_ovf = exp_norm >= SUM_W'(EXP_MAX + EXP_BIAS);

  // <= 0 would need a subnormal, flushed instead
  assign exp_unf = exp_norm <= SUM_W'(EXP_BIAS);

  // only 1..30 reach the output, fits the field
  assign exp_res = EXP_W'(exp_norm - SUM_W'(EXP_BIAS));

  ////////////////////
  // special cases
  ////////////////////

  // priority: zero, infinity, underflow, normal
  always_comb
  begin
    z_next = '0;
    if (meta.is_zero)
    begin
      // covers zero times infinity too
      z_next = '0;
    end
    else if (meta.is_inf || exp_ovf)
    begin
      z_next.sign = meta.sign;
      z_next.exp  = EXP_W'(EXP_MAX);
      z_next.frac = '0;
    end
    else if (exp_unf)
    begin
      // flush to +0, sign dropped
      z_next = '0;
    end
    else
    begin
      z_next.sign = meta.sign;
      z_next.exp  = exp_res;
      z_next.frac = frac_norm;
    end
  end

  // output register, +0 out of reset
  always_ff @(posedge CLK or posedge Reset)
  begin
    if (Reset)
      z <= '0;
    else
      z <= z_next;
  end

endmodule

//--- src/fpm_multiplier.sv
`timescale 1ns/1ps

module fpm_multiplier (
  input  logic            CLK,
  input  logic            Reset,
  input  fpm_pkg::half_t  a,
  input  fpm_pkg::short_t b,
  output fpm_pkg::half_t  z
);

  import fpm_pkg::*;

  ////////////////////
  // stage wires
  ////////////////////

  // decode out, one row per bit of b
  pp_t      pp_d [B_SIG_W];
  op_meta_t meta_d;

  // adder tree levels
  pp_t      pp_l1 [TREE_N1];
  op_meta_t meta_l1;
  pp_t      pp_l2 [TREE_N2];
  op_meta_t meta_l2;
  pp_t      pp_l3 [TREE_N3];
  op_meta_t meta_l3;

  ////////////////////
  // pipeline
  ////////////////////

  // stage 1, fields and partial products
  fpm_decode u_decode (
    .CLK   (CLK),
    .Reset (Reset),
    .a     (a),
    .b     (b),
    .pp    (pp_d),
    .meta  (meta_d)
  );

  // stages 2 to 4, 5 -> 3 -> 2 -> 1
  fpm_adder_level #(.N_IN(B_SIG_W), .payload_t(op_meta_t)) u_level1 (
    .CLK      (CLK),
    .Reset    (Reset),
    .pp_in    (pp_d),
    .side_in  (meta_d),
    .pp_out   (pp_l1),
    .side_out (meta_l1)
  );

  fpm_adder_level #(.N_IN(TREE_N1), .payload_t(op_meta_t)) u_level2 (
    .CLK      (CLK),
    .Reset    (Reset),
    .pp_in    (pp_l1),
    .side_in  (meta_l1),
    .pp_out   (pp_l2),
    .side_out (meta_l2)
  );

  fpm_adder_level #(.N_IN(TREE_N2), .payload_t(op_meta_t)) u_level3 (
    .CLK      (CLK),
    .Reset    (Reset),
    .pp_in    (pp_l2),
    .side_in  (meta_l2),
    .pp_out   (pp_l3),
    .side_out (meta_l3)
  );

  // stage 5, full product in, packed result out
  fpm_normalize u_normalize (
    .CLK   (CLK),
    .Reset (Reset),
    .prod  (pp_l3[0]),
    .meta  (meta_l3),
    .z     (z)
  );

endmodule

//--- tb/fpm_multiplier_asserts.sv
`timescale 1ns/1ps

module fpm_multiplier_asserts (
  input logic           CLK,
  input logic           Reset,
  input fpm_pkg::half_t z
);

  import fpm_pkg::*;

  ////////////////////
  // reset
  ////////////////////

  // async reset clears every stage, output too
  property p_reset_zero;
    @(posedge CLK) Reset |-> (z == '0);
  endproperty

  a_reset_zero : assert property (p_reset_zero)
    else $error("z not zero while Reset is high");

  ////////////////////
  // result encoding
  ////////////////////

  // infinity only, the multiplier never makes a NaN
  property p_inf_frac;
    @(posedge CLK) disable iff (Reset)
      (z.exp == EXP_W'(EXP_MAX)) |-> (z.frac == '0);
  endproperty

  a_inf_frac : assert property (p_inf_frac)
    else $error("z has exponent 31 with a nonzero fraction");

  // subnormals flushed, only +0 has exponent 0
  property p_zero_flush;
    @(posedge CLK) disable iff (Reset)
      (z.exp == '0) |-> (z == '0);
  endproperty

  a_zero_flush : assert property (p_zero_flush)
    else $error("z has exponent 0 but is not +0");

endmodule

bind fpm_multiplier fpm_multiplier_asserts u_asserts (
  .CLK   (CLK),
  .Reset (Reset),
  .z     (z)
);

//--- tb/fpm_multiplier_tb.sv
`timescale 1ns/1ps

module fpm_multiplier_tb;

  import fpm_pkg::*;

  ////////////////////
  // run length
  ////////////////////

  localparam int RESET_CYCLES   = 3;
  localparam int N_DIRECTED     = 19;
  localparam int N_NORMAL       = 40;
  localparam int N_RANDOM       = 200;
  // stimulus cycles plus slack for pipeline drain
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_DIRECTED + N_NORMAL + N_RANDOM + 20;
  // pipeline depth from input edge k to output edge k+4
  localparam int LATENCY        = 5;

  // expected z and the rising edge it is due after
  typedef struct packed {
    int    due;
    half_t z;
  } expect_t;

  // dut inputs
  logic   CLK   = 1'b0;
  logic   Reset = 1'b1;
  half_t  a     = '0;
  short_t b     = '0;
  half_t  z;

  expect_t     exp_q[$];
  logic [31:0] rng         = 32'd41628;
  int          cycle       = 0;
  int          timeout_cnt = 0;
  int          applied     = 0;
  int          checked     = 0;
  // z must stay +0 before this edge
  int          first_due   = 32'h7fff_ffff;

  fpm_multiplier u_fpm_multiplier (
    .CLK   (CLK),
    .Reset (Reset),
    .a     (a),
    .b     (b),
    .z     (z)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic half_t make_half(input logic s, input int e, input int f);
    half_t r;
    r.sign = s;
    r.exp  = EXP_W'(e);
    r.frac = A_FRAC_W'(f);
    return r;
  endfunction

  function automatic short_t make_short(input logic s, input int e, input int f);
    short_t r;
    r.sign = s;
    r.exp  = EXP_W'(e);
    r.frac = B_FRAC_W'(f);
    return r;
  endfunction

  // expected z straight from the number format
  function automatic half_t ref_multiply(input half_t op_a, input short_t op_b);
    int    sig_a;
    int    sig_b;
    int    prod;
    int    e;
    int    shift;
    half_t r;
    r = '0;
    // hidden ones
    sig_a = (1 << A_FRAC_W) + int'(op_a.frac);
    sig_b = (1 << B_FRAC_W) + int'(op_b.frac);
    prod  = sig_a * sig_b;
    e     = int'(op_a.exp) + int'(op_b.exp) - EXP_BIAS;
    // top bit set means one extra exponent step
    if (prod >= (1 << (PROD_W - 1)))
    begin
      e     = e + 1;
      shift = PROD_W - 1 - A_FRAC_W;
    end
    else
      shift = PROD_W - 2 - A_FRAC_W;
    if (op_a.exp == 0 || op_b.exp == 0)
      r = '0;
    else if (op_a.exp == EXP_W'(EXP_MAX) || op_b.exp == EXP_W'(EXP_MAX) || e >= EXP_MAX)
    begin
      r.sign = op_a.sign ^ op_b.sign;
      r.exp  = EXP_W'(EXP_MAX);
    end
    else if (e <= 0)
      r = '0;
    else
    begin
      r.sign = op_a.sign ^ op_b.sign;
      r.exp  = EXP_W'(e);
      // truncated with no rounding
      r.frac = A_FRAC_W'(prod >> shift);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected)
    begin
      $display("Mismatch at %0d ns: %s = 0x%04h, expected 0x%04h",
               $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // one pair per falling edge
  task automatic apply(input half_t op_a, input short_t op_b);
    expect_t e;
    @(negedge CLK);
    a     = op_a;
    b     = op_b;
    e.due = cycle + LATENCY;
    e.z   = ref_multiply(op_a, op_b);
    if (applied == 0)
      first_due = e.due;
    exp_q.push_back(e);
    applied++;
  endtask

  task automatic run_directed();
    // normal products with and without carry
    apply(make_half(0, 15, 'h200), make_short(0, 15, 'h8));
    apply(make_half(0, 15, 'h000), make_short(0, 15, 'h0));
    apply(make_half(1, 15, 'h300), make_short(0, 15, 'hf));
    apply(make_half(0, 15, 'h000), make_short(1, 15, 'h0));
    // smallest normal result reached only via the carry
    apply(make_half(0, 7, 'h200), make_short(0, 8, 'h8));
    // zero and subnormal operands
    apply(make_half(0, 0, 'h000), make_short(0, 15, 'h0));
    apply(make_half(0, 0, 'h155), make_short(0, 15, 'h8));
    apply(make_half(0, 15, 'h2aa), make_short(0, 0, 'h3));
    apply(make_half(0, 0, 'h000), make_short(0, 31, 'h0));
    apply(make_half(1, 0, 'h000), make_short(1, 17, 'h4));
    // infinite operands with the fraction ignored
    apply(make_half(0, 31, 'h000), make_short(1, 15, 'h0));
    apply(make_half(1, 31, 'h3ff), make_short(0, 10, 'h5));
    apply(make_half(1, 20, 'h0f0), make_short(0, 31, 'h7));
    // overflow into infinity
    apply(make_half(0, 30, 'h100), make_short(1, 20, 'h2));
    // exponent 30 stays normal until the carry pushes it over
    apply(make_half(0, 23, 'h000), make_short(0, 22, 'h0));
    apply(make_half(1, 23, 'h200), make_short(0, 22, 'h8));
    // underflow flush drops the sign
    apply(make_half(0, 5, 'h1ff), make_short(0, 8, 'h3));
    apply(make_half(1, 7, 'h000), make_short(0, 8, 'h0));
    apply(make_half(0, 1, 'h3ff), make_short(0, 1, 'hf));
  endtask

  // exponents 8..22 each keep the result in 1..30
  task automatic run_normal(input int n);
    half_t  op_a;
    short_t op_b;
    int     ea;
    int     eb;
    for (int i = 0; i < n; i++)
    begin
      rng  = xorshift32(rng);
      ea   = 8 + int'(rng[7:0]) % 15;
      eb   = 8 + int'(rng[15:8]) % 15;
      rng  = xorshift32(rng);
      op_a = make_half(rng[31], ea, int'(rng[9:0]));
      op_b = make_short(rng[30], eb, int'(rng[13:10]));
      apply(op_a, op_b);
    end
  endtask

  // any bit pattern back to back
  task automatic run_random(input int n);
    for (int i = 0; i < n; i++)
    begin
      rng = xorshift32(rng);
      apply(half_t'(rng[15:0]), short_t'(rng[25:16]));
    end
  endtask

  initial
  begin
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    Reset = 1'b0;
    run_directed();
    run_normal(N_NORMAL);
    run_random(N_RANDOM);
    // wait for the pipeline to drain
    while (checked < applied)
      @(negedge CLK);
    $display("All checks passed");
    $finish;
  end

  ////////////////////
  // compare
  ////////////////////

  // sample well after the edge once z has settled
  always @(posedge CLK)
  begin
    cycle = cycle + 1;
    #10;
    if (Reset)
      check_value("z", z, '0);
    else if (exp_q.size() > 0 && exp_q[0].due == cycle)
    begin
      check_value("z", z, exp_q[0].z);
      void'(exp_q.pop_front());
      checked++;
    end
    else if (cycle < first_due)
      check_value("z", z, '0);
  end

  // run limit
  always @(posedge CLK)
  begin
    timeout_cnt = timeout_cnt + 1;
    if (timeout_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, %0d of %0d results compared",
               timeout_cnt, checked, applied);
      $display("Checks failed");
      $fatal(1, "simulation did not finish in time");
    end
  end

endmodule

//--- fpm_multiplier.f
src/fpm_pkg.sv
src/fpm_decode.sv
src/fpm_adder_level.sv
src/fpm_normalize.sv
src/fpm_multiplier.sv
tb/fpm_multiplier_asserts.sv
tb/fpm_multiplier_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=fpm_multiplier_tb
BUILD_DIR=build
LOG=sim.log

# compile
verilator --binary --timing --assert \
  -f fpm_multiplier.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# run, keep the output for the search below
"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  exit 0
fi

echo "simulation ended without a result"
exit 1
